/* source/arithDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module arithDecoder
(
        input  wire mipsControlPkg::instrFieldsT fields,
        output mipsControlPkg::decodeResultT     result
);

        logic                  hit;
        logic                  regDst;
        logic                  shamtSelect;
        logic                  immSelect;
        logic                  zeroExtend;
        mipsControlPkg::aluOpT aluOp;

        always_comb
        begin
                hit         = 1'b1;
                regDst      = 1'b0;
                shamtSelect = 1'b0;
                zeroExtend  = 1'b0;
                aluOp       = mipsControlPkg::ALU_NONE;
                case (fields.opcode)
                mipsControlPkg::OP_SPECIAL:
                begin
                        regDst = 1'b1;
                        case (fields.funct)
                        mipsControlPkg::FN_ADD_BSHFL: aluOp = mipsControlPkg::ALU_ADD;
                        mipsControlPkg::FN_ADDU:      aluOp = mipsControlPkg::ALU_ADDU;
                        mipsControlPkg::FN_SUB:       aluOp = mipsControlPkg::ALU_SUB;
                        mipsControlPkg::FN_AND:       aluOp = mipsControlPkg::ALU_AND;
                        mipsControlPkg::FN_OR:        aluOp = mipsControlPkg::ALU_OR;
                        mipsControlPkg::FN_NOR:       aluOp = mipsControlPkg::ALU_NOR;
                        mipsControlPkg::FN_XOR:       aluOp = mipsControlPkg::ALU_XOR;
                        mipsControlPkg::FN_SLT:       aluOp = mipsControlPkg::ALU_SLT;
                        mipsControlPkg::FN_SLTU:      aluOp = mipsControlPkg::ALU_SLTU;
                        mipsControlPkg::FN_MOVN:      aluOp = mipsControlPkg::ALU_MOVN;
                        mipsControlPkg::FN_MOVZ:      aluOp = mipsControlPkg::ALU_MOVZ;
                        mipsControlPkg::FN_SLLV:      aluOp = mipsControlPkg::ALU_SLL;
                        mipsControlPkg::FN_SRAV:      aluOp = mipsControlPkg::ALU_SRAV;
                        mipsControlPkg::FN_SLL:
                        begin
                                aluOp       = mipsControlPkg::ALU_SLL;
                                shamtSelect = 1'b1;
                        end
                        mipsControlPkg::FN_SRA:
                        begin
                                aluOp       = mipsControlPkg::ALU_SRA;
                                shamtSelect = 1'b1;
                        end
                        mipsControlPkg::FN_SRL_MUL:
                        begin
                                shamtSelect = 1'b1;
                                if (fields.rs[0])       // Bit 21 marks ROTR
                                        aluOp = mipsControlPkg::ALU_ROTR;
                                else
                                        aluOp = mipsControlPkg::ALU_SRL;
                        end
                        mipsControlPkg::FN_SRLV:
                        begin
                                if (fields.shamt[0])    // Bit 6 marks ROTRV
                                        aluOp = mipsControlPkg::ALU_ROTR;
                                else
                                        aluOp = mipsControlPkg::ALU_SRL;
                        end
                        default: hit = 1'b0;            // JR and HI/LO fall out here
                        endcase
                end
                mipsControlPkg::OP_SPECIAL2:
                begin
                        regDst = 1'b1;
                        if (fields.funct == mipsControlPkg::FN_SRL_MUL)
                                aluOp = mipsControlPkg::ALU_MUL;
                        else
                                hit = 1'b0;
                end
                mipsControlPkg::OP_SPECIAL3:
                begin
                        regDst = 1'b1;
                        if (fields.funct != mipsControlPkg::FN_ADD_BSHFL)
                                hit = 1'b0;
                        else if (fields.shamt == 5'b10000)
                                aluOp = mipsControlPkg::ALU_SEB;
                        else if (fields.shamt == 5'b11000)
                                aluOp = mipsControlPkg::ALU_SEH;
                        else
                                hit = 1'b0;
                end
                mipsControlPkg::OP_ADDI:  aluOp = mipsControlPkg::ALU_ADD;
                mipsControlPkg::OP_ADDIU: aluOp = mipsControlPkg::ALU_ADDU;
                mipsControlPkg::OP_SLTI:  aluOp = mipsControlPkg::ALU_SLT;
                mipsControlPkg::OP_SLTIU: aluOp = mipsControlPkg::ALU_SLTU_IMM;
                mipsControlPkg::OP_ANDI:
                begin
                        aluOp      = mipsControlPkg::ALU_AND;
                        zeroExtend = 1'b1;
                end
                mipsControlPkg::OP_ORI:
                begin
                        aluOp      = mipsControlPkg::ALU_OR;
                        zeroExtend = 1'b1;
                end
                mipsControlPkg::OP_XORI:
                begin
                        aluOp      = mipsControlPkg::ALU_XOR;
                        zeroExtend = 1'b1;
                end
                default: hit = 1'b0;
                endcase
        end

        // Every non-register form in this group takes the immediate
        assign immSelect = hit & ~regDst;

        always_comb
        begin
                result     = '0;
                result.hit = hit;
                if (hit)
                begin
                        result.control.regWrite    = 1'b1;
                        result.control.regDst      = regDst;
                        result.control.shamtSelect = shamtSelect;
                        result.control.immSelect   = immSelect;
                        result.control.zeroExtend  = zeroExtend;
                        result.control.aluOp       = aluOp;
                end
        end

endmodule

`default_nettype wire

/* source/branchDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module branchDecoder
(
        input  wire mipsControlPkg::instrFieldsT fields,
        output mipsControlPkg::decodeResultT     result
);

        logic                  hit;
        logic                  relativeTarget;
        logic                  link;
        logic                  jumpRegister;
        mipsControlPkg::aluOpT aluOp;

        always_comb
        begin
                hit            = 1'b1;
                relativeTarget = 1'b1;
                link           = 1'b0;
                jumpRegister   = 1'b0;
                aluOp          = mipsControlPkg::ALU_NONE;
                case (fields.opcode)
                mipsControlPkg::OP_BEQ:  aluOp = mipsControlPkg::ALU_BEQ;
                mipsControlPkg::OP_BNE:  aluOp = mipsControlPkg::ALU_BNE;
                mipsControlPkg::OP_BGTZ: aluOp = mipsControlPkg::ALU_BGTZ;
                mipsControlPkg::OP_BLEZ:
                begin
                        aluOp = mipsControlPkg::ALU_BLEZ;
                        hit   = (fields.rt == '0);
                end
                mipsControlPkg::OP_REGIMM:
                begin
                        if (fields.rt == 5'b00001)
                                aluOp = mipsControlPkg::ALU_BGEZ;
                        else if (fields.rt == 5'b00000)
                                aluOp = mipsControlPkg::ALU_BLTZ;
                        else
                                hit = 1'b0;
                end
                mipsControlPkg::OP_J:
                begin
                        aluOp          = mipsControlPkg::ALU_JUMP;
                        relativeTarget = 1'b0;
                end
                mipsControlPkg::OP_JAL:
                begin
                        aluOp          = mipsControlPkg::ALU_JAL;
                        relativeTarget = 1'b0;
                        link           = 1'b1;
                end
                mipsControlPkg::OP_SPECIAL:
                begin
                        // Target comes from rs
                        aluOp          = mipsControlPkg::ALU_JR;
                        relativeTarget = 1'b0;
                        jumpRegister   = 1'b1;
                        hit            = (fields.funct == mipsControlPkg::FN_JR);
                end
                default: hit = 1'b0;
                endcase
        end

        always_comb
        begin
                result     = '0;
                result.hit = hit;
                if (hit)
                begin
                        result.control.branch         = 1'b1;
                        result.control.relativeTarget = relativeTarget;
                        result.control.link           = link;
                        result.control.regWrite       = link;   // Return address
                        result.control.jumpRegister   = jumpRegister;
                        result.control.aluOp          = aluOp;
                end
        end

endmodule

`default_nettype wire

/* source/controlDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module controlDecoder
(
        input  wire [mipsControlPkg::InstrWidth-1:0] instruction,
        output mipsControlPkg::controlWordT          control,
        output logic                                 recognized
);

        mipsControlPkg::instrFieldsT  fields;
        mipsControlPkg::decodeResultT arithResult;
        mipsControlPkg::decodeResultT memoryResult;
        mipsControlPkg::decodeResultT branchResult;

        assign fields = mipsControlPkg::instrFieldsT'(instruction);

        //////////////////////////////////////////////////////////////////////
        // Group decoders

        arithDecoder arith
        (
                .fields (fields),
                .result (arithResult)
        );

        memoryDecoder memory
        (
                .fields (fields),
                .result (memoryResult)
        );

        branchDecoder branch
        (
                .fields (fields),
                .result (branchResult)
        );

        //////////////////////////////////////////////////////////////////////
        // Merge

        // Groups never overlap and a missing group returns zero
        assign control = mipsControlPkg::controlWordT'(arithResult.control
                                                       | memoryResult.control
                                                       | branchResult.control);

        assign recognized = arithResult.hit | memoryResult.hit | branchResult.hit;

endmodule

`default_nettype wire

/* source/memoryDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module memoryDecoder
(
        input  wire mipsControlPkg::instrFieldsT fields,
        output mipsControlPkg::decodeResultT     result
);

        mipsControlPkg::memWidthT readWidth;
        mipsControlPkg::memWidthT writeWidth;
        logic                     isLoad;
        logic                     isStore;
        logic                     isLui;
        logic                     hit;

        always_comb
        begin
                readWidth  = mipsControlPkg::MEM_NONE;
                writeWidth = mipsControlPkg::MEM_NONE;
                isLui      = 1'b0;
                case (fields.opcode)
                mipsControlPkg::OP_LW: readWidth  = mipsControlPkg::MEM_WORD;
                mipsControlPkg::OP_LH: readWidth  = mipsControlPkg::MEM_HALF;
                mipsControlPkg::OP_LB: readWidth  = mipsControlPkg::MEM_BYTE;
                mipsControlPkg::OP_SW: writeWidth = mipsControlPkg::MEM_WORD;
                mipsControlPkg::OP_SH: writeWidth = mipsControlPkg::MEM_HALF;
                mipsControlPkg::OP_SB: writeWidth = mipsControlPkg::MEM_BYTE;
                mipsControlPkg::OP_LUI: isLui = 1'b1;   // ALU only, no access
                default: readWidth = mipsControlPkg::MEM_NONE;
                endcase
        end

        assign isLoad  = (readWidth != mipsControlPkg::MEM_NONE);
        assign isStore = (writeWidth != mipsControlPkg::MEM_NONE);
        assign hit     = isLoad | isStore | isLui;

        always_comb
        begin
                result                    = '0;
                result.hit                = hit;
                result.control.regWrite   = isLoad | isLui;
                result.control.immSelect  = hit;        // Offset or upper immediate
                result.control.zeroExtend = isLui;
                result.control.memRead    = readWidth;
                result.control.memWrite   = writeWidth;
                result.control.memToReg   = isLoad;
                if (isLoad | isStore)
                        result.control.aluOp = mipsControlPkg::ALU_MEM_ADDR;
                else if (isLui)
                        result.control.aluOp = mipsControlPkg::ALU_LUI;
        end

endmodule

`default_nettype wire

/* source/mipsControlPkg.sv */
`default_nettype none

package mipsControlPkg;

        //////////////////////////////////////////////////////////////////////
        // Instruction field widths

        localparam int InstrWidth    = 32;
        localparam int OpcodeWidth   = 6;
        localparam int FunctWidth    = 6;
        localparam int RegFieldWidth = 5;
        localparam int AluOpWidth    = 6;

        //////////////////////////////////////////////////////////////////////
        // Encodings

        typedef enum logic [OpcodeWidth-1:0] {
                OP_SPECIAL  = 6'b000000,
                OP_REGIMM   = 6'b000001,    // BGEZ/BLTZ, picked by rt
                OP_J        = 6'b000010,
                OP_JAL      = 6'b000011,
                OP_BEQ      = 6'b000100,
                OP_BNE      = 6'b000101,
                OP_BLEZ     = 6'b000110,
                OP_BGTZ     = 6'b000111,
                OP_ADDI     = 6'b001000,
                OP_ADDIU    = 6'b001001,
                OP_SLTI     = 6'b001010,
                OP_SLTIU    = 6'b001011,
                OP_ANDI     = 6'b001100,
                OP_ORI      = 6'b001101,
                OP_XORI     = 6'b001110,
                OP_LUI      = 6'b001111,
                OP_SPECIAL2 = 6'b011100,
                OP_SPECIAL3 = 6'b011111,
                OP_LB       = 6'b100000,
                OP_LH       = 6'b100001,
                OP_LW       = 6'b100011,
                OP_SB       = 6'b101000,
                OP_SH       = 6'b101001,
                OP_SW       = 6'b101011
        } opcodeT;

        // Codes reused across SPECIAL, SPECIAL2 and SPECIAL3 carry both names
        typedef enum logic [FunctWidth-1:0] {
                FN_SLL       = 6'b000000,
                FN_SRL_MUL   = 6'b000010,   // SRL/ROTR, MUL under SPECIAL2
                FN_SRA       = 6'b000011,
                FN_SLLV      = 6'b000100,
                FN_SRLV      = 6'b000110,   // SRLV/ROTRV
                FN_SRAV      = 6'b000111,
                FN_JR        = 6'b001000,
                FN_MOVZ      = 6'b001010,
                FN_MOVN      = 6'b001011,
                FN_ADD_BSHFL = 6'b100000,   // ADD, SEB/SEH under SPECIAL3
                FN_ADDU      = 6'b100001,
                FN_SUB       = 6'b100010,
                FN_AND       = 6'b100100,
                FN_OR        = 6'b100101,
                FN_XOR       = 6'b100110,
                FN_NOR       = 6'b100111,
                FN_SLT       = 6'b101010,
                FN_SLTU      = 6'b101011
        } functT;

        typedef enum logic [AluOpWidth-1:0] {
                ALU_NONE     = 6'b000000,
                ALU_SUB      = 6'b000001,
                ALU_AND      = 6'b000010,
                ALU_OR       = 6'b000011,
                ALU_NOR      = 6'b000100,
                ALU_XOR      = 6'b000101,
                ALU_SEH      = 6'b000110,
                ALU_SLL      = 6'b000111,
                ALU_SRL      = 6'b001000,
                ALU_SLT      = 6'b001001,
                ALU_MOVN     = 6'b001010,
                ALU_MOVZ     = 6'b001011,
                ALU_ROTR     = 6'b001100,
                ALU_SRA      = 6'b001101,
                ALU_SRAV     = 6'b001110,
                ALU_SEB      = 6'b001111,
                ALU_SLTU_IMM = 6'b010000,
                ALU_SLTU     = 6'b010001,
                ALU_MUL      = 6'b010010,
                ALU_ADD      = 6'b010011,   // Former MULTU slot
                ALU_ADDU     = 6'b010111,
                ALU_BEQ      = 6'b011100,
                ALU_BNE      = 6'b011101,
                ALU_BGTZ     = 6'b011110,
                ALU_BLEZ     = 6'b011111,
                ALU_BGEZ     = 6'b100000,
                ALU_LUI      = 6'b100001,
                ALU_JR       = 6'b100010,
                ALU_JAL      = 6'b100011,
                ALU_MEM_ADDR = 6'b100100,
                ALU_BLTZ     = 6'b100101,
                ALU_JUMP     = 6'b100110
        } aluOpT;

        typedef enum logic [1:0] {
                MEM_NONE = 2'b00,
                MEM_WORD = 2'b01,
                MEM_HALF = 2'b10,
                MEM_BYTE = 2'b11
        } memWidthT;

        //////////////////////////////////////////////////////////////////////
        // Bundles

        typedef struct packed {
                opcodeT                   opcode;
                logic [RegFieldWidth-1:0] rs;
                logic [RegFieldWidth-1:0] rt;
                logic [RegFieldWidth-1:0] rd;
                logic [RegFieldWidth-1:0] shamt;
                functT                    funct;
        } instrFieldsT;

        typedef struct packed {
                logic     regWrite;
                logic     regDst;           // Write rd instead of rt
                logic     shamtSelect;      // Operand A from shamt
                logic     immSelect;        // Operand B from immediate
                logic     zeroExtend;
                memWidthT memRead;
                memWidthT memWrite;
                logic     memToReg;
                logic     branch;
                logic     relativeTarget;   // PC relative, else absolute
                logic     link;
                logic     jumpRegister;
                aluOpT    aluOp;
        } controlWordT;

        typedef struct packed {
                logic        hit;
                controlWordT control;
        } decodeResultT;

endpackage

`default_nettype wire

/* src.f */
+incdir+verification
source/mipsControlPkg.sv
source/arithDecoder.sv
source/memoryDecoder.sv
source/branchDecoder.sv
source/controlDecoder.sv
verification/controlDecoderTb.sv

/* verification/decodeVectors.svh */
//////////////////////////////////////////////////////////////////////
// Each row is the instruction with rd zero, flags, memRead, memWrite and aluOp
// Flags run regWrite regDst shamtSelect immSelect zeroExtend
// then memToReg branch relativeTarget link jumpRegister

addRow(32'h00430020, 10'b11000_00000, 2'd0, 2'd0, mipsControlPkg::ALU_ADD);       // ADD
addRow(32'h00430021, 10'b11000_00000, 2'd0, 2'd0, mipsControlPkg::ALU_ADDU);      // ADDU
addRow(32'h00430022, 10'b11000_00000, 2'd0, 2'd0, mipsControlPkg::ALU_SUB);       // SUB
addRow(32'h00430024, 10'b11000_00000, 2'd0, 2'd0, mipsControlPkg::ALU_AND);       // AND
addRow(32'h00430025, 10'b11000_00000, 2'd0, 2'd0, mipsControlPkg::ALU_OR);        // OR
addRow(32'h00430027, 10'b11000_00000, 2'd0, 2'd0, mipsControlPkg::ALU_NOR);       // NOR
addRow(32'h00430026, 10'b11000_00000, 2'd0, 2'd0, mipsControlPkg::ALU_XOR);       // XOR
addRow(32'h0043002A, 10'b11000_00000, 2'd0, 2'd0, mipsControlPkg::ALU_SLT);       // SLT
addRow(32'h0043002B, 10'b11000_00000, 2'd0, 2'd0, mipsControlPkg::ALU_SLTU);      // SLTU
addRow(32'h0043000B, 10'b11000_00000, 2'd0, 2'd0, mipsControlPkg::ALU_MOVN);      // MOVN
addRow(32'h0043000A, 10'b11000_00000, 2'd0, 2'd0, mipsControlPkg::ALU_MOVZ);      // MOVZ
addRow(32'h00430004, 10'b11000_00000, 2'd0, 2'd0, mipsControlPkg::ALU_SLL);       // SLLV
addRow(32'h00430006, 10'b11000_00000, 2'd0, 2'd0, mipsControlPkg::ALU_SRL);       // SRLV
addRow(32'h00430046, 10'b11000_00000, 2'd0, 2'd0, mipsControlPkg::ALU_ROTR);      // ROTRV
addRow(32'h00430007, 10'b11000_00000, 2'd0, 2'd0, mipsControlPkg::ALU_SRAV);      // SRAV
addRow(32'h00000000, 10'b11100_00000, 2'd0, 2'd0, mipsControlPkg::ALU_SLL);       // NOP is SLL
addRow(32'h00030100, 10'b11100_00000, 2'd0, 2'd0, mipsControlPkg::ALU_SLL);       // SLL
addRow(32'h00030102, 10'b11100_00000, 2'd0, 2'd0, mipsControlPkg::ALU_SRL);       // SRL
addRow(32'h00230102, 10'b11100_00000, 2'd0, 2'd0, mipsControlPkg::ALU_ROTR);      // ROTR
addRow(32'h00030103, 10'b11100_00000, 2'd0, 2'd0, mipsControlPkg::ALU_SRA);       // SRA
addRow(32'h70430002, 10'b11000_00000, 2'd0, 2'd0, mipsControlPkg::ALU_MUL);       // MUL
addRow(32'h7C030420, 10'b11000_00000, 2'd0, 2'd0, mipsControlPkg::ALU_SEB);       // SEB
addRow(32'h7C030620, 10'b11000_00000, 2'd0, 2'd0, mipsControlPkg::ALU_SEH);       // SEH
addRow(32'h20430005, 10'b10010_00000, 2'd0, 2'd0, mipsControlPkg::ALU_ADD);       // ADDI
addRow(32'h24430005, 10'b10010_00000, 2'd0, 2'd0, mipsControlPkg::ALU_ADDU);      // ADDIU
addRow(32'h28430005, 10'b10010_00000, 2'd0, 2'd0, mipsControlPkg::ALU_SLT);       // SLTI
addRow(32'h2C430005, 10'b10010_00000, 2'd0, 2'd0, mipsControlPkg::ALU_SLTU_IMM);  // SLTIU
addRow(32'h30430005, 10'b10011_00000, 2'd0, 2'd0, mipsControlPkg::ALU_AND);       // ANDI
addRow(32'h34430005, 10'b10011_00000, 2'd0, 2'd0, mipsControlPkg::ALU_OR);        // ORI
addRow(32'h38430005, 10'b10011_00000, 2'd0, 2'd0, mipsControlPkg::ALU_XOR);       // XORI
addRow(32'h8C430010, 10'b10010_10000, 2'd1, 2'd0, mipsControlPkg::ALU_MEM_ADDR);  // LW
addRow(32'h84430010, 10'b10010_10000, 2'd2, 2'd0, mipsControlPkg::ALU_MEM_ADDR);  // LH
addRow(32'h80430010, 10'b10010_10000, 2'd3, 2'd0, mipsControlPkg::ALU_MEM_ADDR);  // LB
addRow(32'hAC430010, 10'b00010_00000, 2'd0, 2'd1, mipsControlPkg::ALU_MEM_ADDR);  // SW
addRow(32'hA4430010, 10'b00010_00000, 2'd0, 2'd2, mipsControlPkg::ALU_MEM_ADDR);  // SH
addRow(32'hA0430010, 10'b00010_00000, 2'd0, 2'd3, mipsControlPkg::ALU_MEM_ADDR);  // SB
addRow(32'h3C031234, 10'b10011_00000, 2'd0, 2'd0, mipsControlPkg::ALU_LUI);       // LUI
addRow(32'h10430008, 10'b00000_01100, 2'd0, 2'd0, mipsControlPkg::ALU_BEQ);       // BEQ
addRow(32'h14430008, 10'b00000_01100, 2'd0, 2'd0, mipsControlPkg::ALU_BNE);       // BNE
addRow(32'h1C400008, 10'b00000_01100, 2'd0, 2'd0, mipsControlPkg::ALU_BGTZ);      // BGTZ
addRow(32'h18400008, 10'b00000_01100, 2'd0, 2'd0, mipsControlPkg::ALU_BLEZ);      // BLEZ
addRow(32'h04410008, 10'b00000_01100, 2'd0, 2'd0, mipsControlPkg::ALU_BGEZ);      // BGEZ
addRow(32'h04400008, 10'b00000_01100, 2'd0, 2'd0, mipsControlPkg::ALU_BLTZ);      // BLTZ
addRow(32'h08000100, 10'b00000_01000, 2'd0, 2'd0, mipsControlPkg::ALU_JUMP);      // J
addRow(32'h0C000100, 10'b10000_01010, 2'd0, 2'd0, mipsControlPkg::ALU_JAL);       // JAL
addRow(32'h00400008, 10'b00000_01001, 2'd0, 2'd0, mipsControlPkg::ALU_JR);        // JR

// Encodings that no group claims
addUnknown(32'hFC000000);       // Unused opcode
addUnknown(32'h00430001);       // Unused SPECIAL function
addUnknown(32'h04420008);       // REGIMM with unused rt
addUnknown(32'h00430018);       // MULT
addUnknown(32'h00000010);       // MFHI
addUnknown(32'h70430000);       // MADD
addUnknown(32'h7C030020);       // BSHFL with other shamt
addUnknown(32'h18430008);       // BLEZ with rt set

/* verification/controlDecoderTb.sv */
`timescale 1ns/1ps
`default_nettype none

module controlDecoderTb;

        logic                                  Clk;
        logic                                  rst;
        logic [mipsControlPkg::InstrWidth-1:0] instruction;
        mipsControlPkg::controlWordT           control;
        logic                                  recognized;

        logic [31:0]                 instrTable[$];
        mipsControlPkg::controlWordT expControl[$];
        logic                        expRecognized[$];
        logic                        vectorsLoaded = 1'b0;
        logic [31:0]                 rdBits;
        integer                      seed;
        integer                      errorCount;
        integer                      checkCount;
        integer                      row;

        controlDecoder DUT
        (
                .instruction (instruction),
                .control     (control),
                .recognized  (recognized)
        );

        initial
        begin
                Clk = 1'b0;
                forever #10 Clk = ~Clk;
        end

        //////////////////////////////////////////////////////////////////////
        // Vector table

        task automatic addRow(input logic [31:0] instr, input logic [9:0] flags,
                              input logic [1:0] readWidth, input logic [1:0] writeWidth,
                              input mipsControlPkg::aluOpT op);
                begin
                        instrTable.push_back(instr);
                        expControl.push_back(mipsControlPkg::controlWordT'(
                                {flags[9:5], readWidth, writeWidth, flags[4:0], op}));
                        expRecognized.push_back(1'b1);
                end
        endtask

        task automatic addUnknown(input logic [31:0] instr);
                begin
                        instrTable.push_back(instr);
                        expControl.push_back('0);       // All inactive
                        expRecognized.push_back(1'b0);
                end
        endtask

        task automatic loadVectors;
                begin
`include "decodeVectors.svh"
                end
        endtask

        task automatic checkField(input string name, input logic [5:0] got,
                                  input logic [5:0] want);
                begin
                        checkCount = checkCount + 1;
                        if (got !== want)
                        begin
                                errorCount = errorCount + 1;
                                $display("FAIL %0d ns: instruction %h, %s is %h, expected %h",
                                         $time, instruction, name, got, want);
                        end
                end
        endtask

        //////////////////////////////////////////////////////////////////////
        // Stimulus and checks

        initial
        begin
                instruction = '0;
                rst         = 1'b1;
                errorCount  = 0;
                checkCount  = 0;
                seed        = 32'h94fd;
                loadVectors();
                vectorsLoaded = 1'b1;
                repeat (8) @(posedge Clk);
                rst <= 1'b0;
                wait (!rst);
                @(posedge Clk);
                for (row = 0; row < instrTable.size(); row = row + 1)
                begin
                        rdBits = $random(seed);         // rd is never decoded
                        instruction <= {instrTable[row][31:16], rdBits[4:0],
                                        instrTable[row][10:0]};
                        @(negedge Clk);
                        checkField("regWrite", control.regWrite, expControl[row].regWrite);
                        checkField("regDst", control.regDst, expControl[row].regDst);
                        checkField("shamtSelect", control.shamtSelect,
                                   expControl[row].shamtSelect);
                        checkField("immSelect", control.immSelect, expControl[row].immSelect);
                        checkField("zeroExtend", control.zeroExtend, expControl[row].zeroExtend);
                        checkField("memRead", control.memRead, expControl[row].memRead);
                        checkField("memWrite", control.memWrite, expControl[row].memWrite);
                        checkField("memToReg", control.memToReg, expControl[row].memToReg);
                        checkField("branch", control.branch, expControl[row].branch);
                        checkField("relativeTarget", control.relativeTarget,
                                   expControl[row].relativeTarget);
                        checkField("link", control.link, expControl[row].link);
                        checkField("jumpRegister", control.jumpRegister,
                                   expControl[row].jumpRegister);
                        checkField("aluOp", control.aluOp, expControl[row].aluOp);
                        checkField("recognized", recognized, expRecognized[row]);
                        @(posedge Clk);
                end
                $display("Checks: %0d, errors: %0d, vectors: %0d",
                         checkCount, errorCount, instrTable.size());
                if (errorCount == 0)
                        $display("test passed");
                else
                        $display("test failed");
                $finish;
        end

        // Watchdog sized from reset plus one cycle per row and some margin
        initial
        begin
                integer limit;
                wait (vectorsLoaded);
                limit = (8 + instrTable.size() + 10) * 20;
                #(limit);
                $display("Timeout: the vector loop did not finish within %0d ns", limit);
                $display("test failed");
                $finish;
        end

endmodule

`default_nettype wire
